// ==== common/approx_mult_pkg.sv ====
`default_nettype none

package approx_mult_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // top level widths
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int OPERAND_WIDTH = 8;
    localparam int PRODUCT_WIDTH = 16;

    // low bits peeled off at each recursion level
    localparam int TOP_SPLIT = 2;  // 8 -> 6 + 2
    localparam int MID_SPLIT = 3;  // 6 -> 3 + 3

    // width of the high part handed to rr_6x6
    localparam int MID_WIDTH = OPERAND_WIDTH - TOP_SPLIT;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // OR-approximated low bits per final adder
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int TOP_APPROX_BITS = 5;  // approx_mult8
    localparam int MID_APPROX_BITS = 2;  // rr_6x6
    localparam int HI3_APPROX_BITS = 2;  // rr_3x3_hi

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // vector types
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef logic [OPERAND_WIDTH-1:0] operand_t;
    typedef logic [PRODUCT_WIDTH-1:0] product_t;

    // rr_6x6 ports
    typedef logic [MID_WIDTH-1:0]   operand6_t;
    typedef logic [2*MID_WIDTH-1:0] product12_t;

    // 3x3 block ports
    typedef logic [MID_SPLIT-1:0]   operand3_t;
    typedef logic [2*MID_SPLIT-1:0] product6_t;

endpackage

`default_nettype wire

// ==== hw/approx_adder.sv ====
`default_nettype none

// low APPROX_BITS are a plain OR, no carry out of that region;
// bits above form an exact sum with carry-in zero
module approx_adder #(
    parameter int A_WIDTH     = 8,
    parameter int B_WIDTH     = 8,
    parameter int APPROX_BITS = 0
) (
    input  logic [A_WIDTH-1:0] op_a,
    input  logic [B_WIDTH-1:0] op_b,
    output logic [A_WIDTH:0]   sum
);

    // op_b is never the wider operand
    logic [A_WIDTH-1:0]           b_ext;
    logic [A_WIDTH-APPROX_BITS:0] hi_sum;

    assign b_ext = A_WIDTH'(op_b);  // zero extend

    // exact upper segment
    assign hi_sum = {1'b0, op_a[A_WIDTH-1:APPROX_BITS]}
                  + {1'b0, b_ext[A_WIDTH-1:APPROX_BITS]};

    generate
        if (APPROX_BITS == 0) begin : g_exact
            assign sum = hi_sum;
        end else begin : g_approx
            logic [APPROX_BITS-1:0] lo_or;

            assign lo_or = op_a[APPROX_BITS-1:0] | b_ext[APPROX_BITS-1:0];
            assign sum   = {hi_sum, lo_or};
        end
    endgenerate

endmodule

`default_nettype wire

// ==== rr_6x6/rr_3x3_hi.sv ====
`default_nettype none

// 3x3 block, operands split as 2 high bits over 1 low bit
module rr_3x3_hi import approx_mult_pkg::*; (
    input  operand3_t a,
    input  operand3_t b,
    output product6_t p
);

    logic [1:0] a_h, b_h;
    logic       a_l, b_l;

    logic [3:0] p_hh;
    logic [1:0] p_hl, p_lh;
    logic       p_ll;

    logic [4:0] operand1;
    logic [2:0] operand2;
    logic [5:0] sum;

    assign a_h = a[2:1];
    assign b_h = b[2:1];
    assign a_l = a[0];
    assign b_l = b[0];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // exact partial products
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign p_hh = a_h * b_h;
    assign p_hl = a_h * b_l;
    assign p_lh = a_l * b_h;
    assign p_ll = a_l * b_l;

    // 1-bit low product has no upper part, pad with a zero
    assign operand1 = {p_hh, 1'b0};

    approx_adder #(
        .A_WIDTH    (2),
        .B_WIDTH    (2),
        .APPROX_BITS(0)
    ) cross_adder (
        .op_a(p_hl),
        .op_b(p_lh),
        .sum (operand2)
    );

    approx_adder #(
        .A_WIDTH    (5),
        .B_WIDTH    (3),
        .APPROX_BITS(HI3_APPROX_BITS)
    ) final_adder (
        .op_a(operand1),
        .op_b(operand2),
        .sum (sum)
    );

    assign p = {sum[4:0], p_ll};  // carry out of sum dropped

endmodule

`default_nettype wire

// ==== rr_6x6/rr_3x3_lo.sv ====
`default_nettype none

// 3x3 block, operands split as 1 high bit over 2 low bits
module rr_3x3_lo import approx_mult_pkg::*; (
    input  operand3_t a,
    input  operand3_t b,
    output product6_t p
);

    logic       a_h, b_h;
    logic [1:0] a_l, b_l;

    logic       p_hh;
    logic [1:0] p_hl, p_lh;
    logic [3:0] p_ll;

    logic [2:0] operand1;
    logic [2:0] operand2;
    logic [3:0] sum;

    assign a_h = a[2];
    assign b_h = b[2];
    assign a_l = a[1:0];
    assign b_l = b[1:0];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // exact partial products
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign p_hh = a_h * b_h;
    assign p_hl = a_h * b_l;
    assign p_lh = a_l * b_h;
    assign p_ll = a_l * b_l;

    // upper half of low product sits under the high product
    assign operand1 = {p_hh, p_ll[3:2]};

    approx_adder #(
        .A_WIDTH    (2),
        .B_WIDTH    (2),
        .APPROX_BITS(0)
    ) cross_adder (
        .op_a(p_hl),
        .op_b(p_lh),
        .sum (operand2)
    );

    // both adders exact at this level
    approx_adder #(
        .A_WIDTH    (3),
        .B_WIDTH    (3),
        .APPROX_BITS(0)
    ) final_adder (
        .op_a(operand1),
        .op_b(operand2),
        .sum (sum)
    );

    assign p = {sum, p_ll[1:0]};

endmodule

`default_nettype wire

// ==== rr_6x6/rr_6x6.sv ====
`default_nettype none

// 6x6 recursive block, split 3/3
module rr_6x6 import approx_mult_pkg::*; (
    input  operand6_t  a,
    input  operand6_t  b,
    output product12_t p
);

    operand3_t a_h, b_h;
    operand3_t a_l, b_l;

    product6_t p_hh;
    product6_t p_hl;
    product6_t p_lh;
    product6_t p_ll;

    logic [2*MID_WIDTH-MID_SPLIT-1:0] operand1;  // 9 bits
    logic [2*MID_SPLIT:0]             operand2;  // 7 bits
    logic [2*MID_WIDTH-MID_SPLIT:0]   sum;       // 10 bits

    assign a_h = a[MID_WIDTH-1:MID_SPLIT];
    assign b_h = b[MID_WIDTH-1:MID_SPLIT];
    assign a_l = a[MID_SPLIT-1:0];
    assign b_l = b[MID_SPLIT-1:0];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // partial products
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    rr_3x3_hi hh_mult (
        .a(a_h),
        .b(b_h),
        .p(p_hh)
    );

    rr_3x3_lo hl_mult (
        .a(a_h),
        .b(b_l),
        .p(p_hl)
    );

    assign p_lh = a_l * b_h;  // exact
    assign p_ll = a_l * b_l;  // exact

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // combine
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign operand1 = {p_hh, p_ll[2*MID_SPLIT-1:MID_SPLIT]};

    approx_adder #(
        .A_WIDTH    (2*MID_SPLIT),
        .B_WIDTH    (2*MID_SPLIT),
        .APPROX_BITS(0)
    ) cross_adder (
        .op_a(p_hl),
        .op_b(p_lh),
        .sum (operand2)
    );

    approx_adder #(
        .A_WIDTH    (2*MID_WIDTH-MID_SPLIT),
        .B_WIDTH    (2*MID_SPLIT+1),
        .APPROX_BITS(MID_APPROX_BITS)
    ) final_adder (
        .op_a(operand1),
        .op_b(operand2),
        .sum (sum)
    );

    // top carry of sum is dropped
    assign p = {sum[2*MID_WIDTH-MID_SPLIT-1:0], p_ll[MID_SPLIT-1:0]};

endmodule

`default_nettype wire

// ==== hw/approx_mult8.sv ====
`default_nettype none

// 8x8 unsigned approximate multiplier
// high 6 bits go through rr_6x6, the low 2 bits stay exact
module approx_mult8 import approx_mult_pkg::*; (
    input  operand_t a,
    input  operand_t b,
    output product_t p
);

    operand6_t            a_h, b_h;
    logic [TOP_SPLIT-1:0] a_l, b_l;

    product12_t                       p_hh;
    logic [MID_WIDTH+TOP_SPLIT-1:0]   p_hl;  // 6x2
    logic [MID_WIDTH+TOP_SPLIT-1:0]   p_lh;  // 2x6
    logic [2*TOP_SPLIT-1:0]           p_ll;  // 2x2

    logic [PRODUCT_WIDTH-TOP_SPLIT-1:0] operand1;  // 14 bits
    logic [MID_WIDTH+TOP_SPLIT:0]       operand2;  // 9 bits
    logic [PRODUCT_WIDTH-TOP_SPLIT:0]   sum;       // 15 bits

    assign a_h = a[OPERAND_WIDTH-1:TOP_SPLIT];
    assign b_h = b[OPERAND_WIDTH-1:TOP_SPLIT];
    assign a_l = a[TOP_SPLIT-1:0];
    assign b_l = b[TOP_SPLIT-1:0];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // partial products
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    rr_6x6 hh_mult (
        .a(a_h),
        .b(b_h),
        .p(p_hh)
    );

    // the small ones stay exact
    assign p_hl = a_h * b_l;
    assign p_lh = a_l * b_h;
    assign p_ll = a_l * b_l;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // combine
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign operand1 = {p_hh, p_ll[2*TOP_SPLIT-1:TOP_SPLIT]};

    // cross products summed exactly
    approx_adder #(
        .A_WIDTH    (MID_WIDTH+TOP_SPLIT),
        .B_WIDTH    (MID_WIDTH+TOP_SPLIT),
        .APPROX_BITS(0)
    ) cross_adder (
        .op_a(p_hl),
        .op_b(p_lh),
        .sum (operand2)
    );

    approx_adder #(
        .A_WIDTH    (PRODUCT_WIDTH-TOP_SPLIT),
        .B_WIDTH    (MID_WIDTH+TOP_SPLIT+1),
        .APPROX_BITS(TOP_APPROX_BITS)
    ) final_adder (
        .op_a(operand1),
        .op_b(operand2),
        .sum (sum)
    );

    // low product bits pass straight through, adder carry out dropped
    assign p = {sum[PRODUCT_WIDTH-TOP_SPLIT-1:0], p_ll[TOP_SPLIT-1:0]};

endmodule

`default_nettype wire

// ==== hw/mult_unit.sv ====
`default_nettype none

// two-stage wrapper around approx_mult8
// operands in at edge N, product out at edge N+2
module mult_unit import approx_mult_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    input  operand_t a,
    input  operand_t b,
    output logic     out_valid,
    output product_t p
);

    operand_t a_q;
    operand_t b_q;
    logic     valid_q;
    product_t p_comb;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stage 1, operand capture
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            a_q <= a;
            b_q <= b;
        end
    end

    approx_mult8 mult_inst (
        .a(a_q),
        .b(b_q),
        .p(p_comb)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stage 2, product register
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= valid_q;  // one-cycle strobe, no hold
        end
    end

    always_ff @(posedge clk) begin
        if (valid_q) begin
            p <= p_comb;
        end
    end

endmodule

`default_nettype wire

// ==== tests/mult_unit_properties.sv ====
`default_nettype none

module mult_unit_properties import approx_mult_pkg::*; (
    input logic     clk,
    input logic     rst_n,
    input logic     in_valid,
    input operand_t a,
    input operand_t b,
    input logic     out_valid,
    input product_t p
);

    timeunit 1ns;
    timeprecision 1ps;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // strobe timing
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    reset_quiet: assert property (@(posedge clk) !rst_n |-> !out_valid)
        else $error("out_valid high while rst_n is low");

    valid_latency: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid == $past(in_valid, 2))
        else $error("out_valid does not follow in_valid by two cycles");

    // a zero operand gives an exact zero
    zero_product: assert property (@(posedge clk) disable iff (!rst_n)
        ($past(in_valid, 2) && ($past(a, 2) == '0 || $past(b, 2) == '0)) |-> p == '0)
        else $error("nonzero product for a zero operand");

endmodule

bind mult_unit mult_unit_properties props_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_valid (in_valid),
    .a        (a),
    .b        (b),
    .out_valid(out_valid),
    .p        (p)
);

`default_nettype wire

// ==== tests/mult_unit_tb.sv ====
`default_nettype none

module mult_unit_tb import approx_mult_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_DIRECTED = 16;
    localparam int NUM_STREAM   = 40;
    localparam int NUM_GAPPED   = 24;

    logic     clk = 1'b0;
    logic     rst_n;
    logic     in_valid;
    operand_t a;
    operand_t b;
    logic     out_valid;
    product_t p;

    int       edge_count = 0;
    int       next_id    = 0;
    int       test_count = 0;
    int       fail_count = 0;
    int       err_count  = 0;
    bit       timed_out  = 1'b0;
    integer   seed       = 32'hee5dbd8e;
    product_t tab_p [NUM_DIRECTED];

    // items in flight with the oldest first
    int       id_q[$];
    operand_t a_hist[$];
    operand_t b_hist[$];
    product_t exp_q[$];
    int       edge_q[$];

    // {a, b}
    logic [15:0] pairs [NUM_DIRECTED] = '{
        16'h00_00, 16'h00_ff, 16'hff_00, 16'h01_01,  // zeros, ones
        16'h01_ff, 16'hff_01, 16'hff_ff, 16'h80_80,
        16'h02_40, 16'h10_08, 16'hfc_fc, 16'h03_03,  // powers of two, high only, low only
        16'hfc_03, 16'h03_fc, 16'haa_55, 16'h7f_81
    };

    mult_unit mult_unit_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .a        (a),
        .b        (b),
        .out_valid(out_valid),
        .p        (p)
    );

    always #10 clk = ~clk;

    always @(posedge clk) edge_count <= edge_count + 1;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic logic [31:0] approx_sum(input logic [31:0] x, input logic [31:0] y,
                                              input int width, input int approx);
        logic [31:0] lo;
        logic [31:0] hi;
        lo = (x | y) & ((32'd1 << approx) - 1);  // no carry out of here
        hi = (x >> approx) + (y >> approx);
        return ((hi << approx) | lo) & ((32'd1 << (width + 1)) - 1);
    endfunction

    function automatic logic [31:0] mult3_hi(input logic [31:0] x, input logic [31:0] y);
        logic [31:0] hh, hl, lh, ll, s;
        hh = (x >> 1) * (y >> 1);
        hl = (x >> 1) * (y & 1);
        lh = (x & 1) * (y >> 1);
        ll = (x & 1) * (y & 1);
        s  = approx_sum(hh << 1, approx_sum(hl, lh, 2, 0), 5, HI3_APPROX_BITS);
        return ((s & 32'h1f) << 1) | ll;
    endfunction

    function automatic logic [31:0] mult3_lo(input logic [31:0] x, input logic [31:0] y);
        logic [31:0] hh, hl, lh, ll, s;
        hh = (x >> 2) * (y >> 2);
        hl = (x >> 2) * (y & 3);
        lh = (x & 3) * (y >> 2);
        ll = (x & 3) * (y & 3);
        s  = approx_sum((hh << 2) | (ll >> 2), approx_sum(hl, lh, 2, 0), 3, 0);
        return (s << 2) | (ll & 3);
    endfunction

    function automatic logic [31:0] mult6(input logic [31:0] x, input logic [31:0] y);
        logic [31:0] hh, hl, lh, ll, s;
        hh = mult3_hi(x >> 3, y >> 3);
        hl = mult3_lo(x >> 3, y & 7);
        lh = (x & 7) * (y >> 3);
        ll = (x & 7) * (y & 7);
        s  = approx_sum((hh << 3) | (ll >> 3), approx_sum(hl, lh, 6, 0), 9, MID_APPROX_BITS);
        return ((s & 32'h1ff) << 3) | (ll & 7);
    endfunction

    function automatic logic [31:0] mult8_expected(input operand_t x, input operand_t y);
        logic [31:0] hh, hl, lh, ll, s;
        hh = mult6(x >> 2, y >> 2);
        hl = (x >> 2) * (y & 3);
        lh = (x & 3) * (y >> 2);
        ll = (x & 3) * (y & 3);
        s  = approx_sum((hh << 2) | (ll >> 2), approx_sum(hl, lh, 8, 0), 14, TOP_APPROX_BITS);
        return ((s & 32'h3fff) << 2) | (ll & 3);
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // driver
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic send_item(input operand_t x, input operand_t y, input product_t expected);
        @(posedge clk);
        #1;
        in_valid = 1'b1;
        a        = x;
        b        = y;
        id_q.push_back(next_id);
        a_hist.push_back(x);
        b_hist.push_back(y);
        exp_q.push_back(expected);
        edge_q.push_back(edge_count + 1);  // edge that samples it
        next_id++;
    endtask

    task automatic stop_driving();
        @(posedge clk);
        #1;
        in_valid = 1'b0;
    endtask

    task automatic wait_drain(input int limit);
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < limit) begin
            @(posedge clk);
            n++;
        end
        if (exp_q.size() != 0) begin
            $display("timeout: %0d results still missing after %0d cycles", exp_q.size(), limit);
            timed_out = 1'b1;
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // monitor samples away from the rising edge
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic check_output(input bit present);
        int       id;
        operand_t xa;
        operand_t xb;
        product_t expected;
        int       latency;
        bit       ok;
        id       = id_q.pop_front();
        xa       = a_hist.pop_front();
        xb       = b_hist.pop_front();
        expected = exp_q.pop_front();
        latency  = edge_count + 1 - edge_q.pop_front();
        ok       = present;
        if (!present) begin
            $display("no result for test %0d two cycles after it was sent", id);
            err_count++;
        end else begin
            assert (latency == 2) else begin
                $display("test %0d arrived after %0d cycles instead of 2", id, latency);
                ok = 1'b0;
                err_count++;
            end
            assert (p === expected) else begin
                $display("FAILED p: expected %h, got %h", expected, p);
                ok = 1'b0;
                err_count++;
            end
        end
        test_count++;
        if (!ok) fail_count++;
        $display("test %0d: a=%h b=%h p=%h %s", id, xa, xb, p, ok ? "ok" : "mismatch");
    endtask

    always @(negedge clk) begin
        assert (!$isunknown(out_valid)) else begin
            $display("out_valid is unknown");
            err_count++;
        end
        if (out_valid === 1'b1) begin
            assert (exp_q.size() != 0) else begin
                $display("out_valid high with no item in flight");
                err_count++;
            end
            if (exp_q.size() != 0) check_output(1'b1);
        end else if (exp_q.size() != 0 && edge_count + 1 - edge_q[0] >= 2) begin
            check_output(1'b0);
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // test sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        operand_t ra;
        operand_t rb;
        rst_n    = 1'b0;
        in_valid = 1'b0;
        a        = '0;
        b        = '0;
        for (int i = 0; i < NUM_DIRECTED; i++) begin
            tab_p[i] = product_t'(mult8_expected(pairs[i][15:8], pairs[i][7:0]));
        end

        repeat (4) @(posedge clk);
        #1 rst_n = 1'b1;
        repeat (3) @(posedge clk);  // idle while the monitor flags any stray out_valid

        // one item at a time
        for (int i = 0; i < NUM_DIRECTED && !timed_out; i++) begin
            send_item(pairs[i][15:8], pairs[i][7:0], tab_p[i]);
            stop_driving();
            wait_drain(8);
        end

        // back to back, then with random gaps
        for (int i = 0; i < NUM_STREAM + NUM_GAPPED && !timed_out; i++) begin
            if (i >= NUM_STREAM && ($random(seed) & 3) == 0) begin
                stop_driving();
            end else begin
                ra = operand_t'($random(seed));
                rb = operand_t'($random(seed));
                send_item(ra, rb, product_t'(mult8_expected(ra, rb)));
            end
        end
        stop_driving();
        if (!timed_out) wait_drain(8);

        $display("tests run %0d of %0d, failed %0d, check errors %0d",
                 test_count, next_id, fail_count, err_count);
        if (err_count == 0 && !timed_out && test_count == next_id) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
common/approx_mult_pkg.sv
hw/approx_adder.sv
rr_6x6/rr_3x3_hi.sv
rr_6x6/rr_3x3_lo.sv
rr_6x6/rr_6x6.sv
hw/approx_mult8.sv
hw/mult_unit.sv
tests/mult_unit_properties.sv
tests/mult_unit_tb.sv

// ==== Makefile ====
# Verilator build and run for the approximate multiplier unit

TOP     := mult_unit_tb
OBJ_DIR := obj_dir
LOG     := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run $(TOP), check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f \
		--top-module $(TOP) -Mdir $(OBJ_DIR) -o $(TOP)
	./$(OBJ_DIR)/$(TOP) | tee $(LOG)
	@if grep -q "Simulation finished: PASS" $(LOG); then \
		echo "test passed"; \
	else \
		echo "test failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
